// File: Makefile
TOOL      = verilator
FLAGS     = --timing --assert
TOP       = rename_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/rename_assert.sv
/* Rename slice assertions
   Back-pressure, slot ordering and ROB occupancy rules */
`timescale 1ns/1ns

module rename_assert (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   rename_rdy,
    input logic [1:0]             ren_valid,
    input logic [1:0]             rat_we,
    input rename_pkg::rob_count_t alloc_count
);

    // Stalled stage shows nothing valid
    a_stall_invalid: assert property (@(posedge clk) disable iff (!rst_n)
        !rename_rdy |-> (ren_valid == 2'b00))
        else $error("ren_valid high while rename_rdy low");

    // No alias update while stalled
    a_stall_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        !rename_rdy |-> (rat_we == 2'b00))
        else $error("alias write while rename_rdy low");

    // Compacted output, slot 1 never alone
    a_slot_order: assert property (@(posedge clk) disable iff (!rst_n)
        ren_valid[1] |-> ren_valid[0])
        else $error("ren_valid slot 1 without slot 0");

    a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_count <= rename_pkg::rob_count_t'(rename_pkg::rob_depth))
        else $error("allocator count above ROB depth");

endmodule

bind rename_top rename_assert rename_assert_i (
    .clk(clk), .rst_n(rst_n), .rename_rdy(rename_rdy), .ren_valid(ren_valid),
    .rat_we(rat_we), .alloc_count(rob_tag_alloc_i.count)
);

// File: test/rename_tb.sv
/* Rename slice testbench
   Table-driven rename, forwarding, bypass, compaction, stall and flush checks */
`timescale 1ns/1ns

module rename_tb;

    logic clk, rst_n, flush, dispatch_rdy, rename_rdy;
    logic [1:0] dec_valid, dec_has_rd, commit_we, ren_valid, ren_has_rd;
    logic [1:0] ren_rs1_renamed, ren_rs2_renamed;
    rename_pkg::arch_reg_t [1:0] dec_rd, dec_rs1, dec_rs2, commit_rd, ren_rd;
    rename_pkg::rob_tag_t  [1:0] commit_tag, ren_dest_tag, ren_rs1_tag, ren_rs2_tag;
    rename_pkg::xlen_t     [1:0] commit_data, ren_rs1_data, ren_rs2_data;

    // --------------------
    // Stimulus table
    // --------------------
    // Sources packed as {rs2_1 rs1_1 rs2_0 rs1_0}
    // Expected tags and bypass picks packed by output slot
    logic [1:0]  t_valid[32], t_has_rd[32], t_cwe[32], t_ev[32], t_e1[32], t_e2[32];
    logic [9:0]  t_rd[32], t_crd[32];
    logic [19:0] t_src[32];
    logic [7:0]  t_ctag[32], t_byp[32];
    logic [15:0] t_stag[32];
    logic        t_disp[32], t_flush[32], t_rdy[32];
    int          n_rows = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    integer      seed = 32'hbf9c_6001;
    // Committed register values and next expected tag
    rename_pkg::xlen_t    shadow[32];
    rename_pkg::rob_tag_t next_tag;

    tb_clock tb_clock_i (.clk(clk), .rst_n(rst_n));

    rename_top rename_top_i (
        .clk(clk), .rst_n(rst_n), .flush(flush), .dec_valid(dec_valid), .dec_rd(dec_rd),
        .dec_has_rd(dec_has_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
        .rename_rdy(rename_rdy), .dispatch_rdy(dispatch_rdy), .ren_valid(ren_valid),
        .ren_dest_tag(ren_dest_tag), .ren_rd(ren_rd), .ren_has_rd(ren_has_rd),
        .ren_rs1_renamed(ren_rs1_renamed), .ren_rs1_tag(ren_rs1_tag),
        .ren_rs1_data(ren_rs1_data), .ren_rs2_renamed(ren_rs2_renamed),
        .ren_rs2_tag(ren_rs2_tag), .ren_rs2_data(ren_rs2_data), .commit_we(commit_we),
        .commit_rd(commit_rd), .commit_tag(commit_tag), .commit_data(commit_data)
    );

    task automatic add_row(input logic [1:0] v, hr, input logic [4:0] rd0, rd1,
                           input logic [4:0] s10, s20, s11, s21, input logic disp,
                           input logic [1:0] cwe, input logic [4:0] crd0, crd1,
                           input logic [3:0] ct0, ct1, input logic fl, rdy,
                           input logic [1:0] ev, e1, e2, input logic [15:0] stag,
                           input logic [7:0] byp);
        t_valid[n_rows] = v;
        t_has_rd[n_rows] = hr;
        t_rd[n_rows] = {rd1, rd0};
        t_src[n_rows] = {s21, s11, s20, s10};
        t_disp[n_rows] = disp;
        t_cwe[n_rows] = cwe;
        t_crd[n_rows] = {crd1, crd0};
        t_ctag[n_rows] = {ct1, ct0};
        t_flush[n_rows] = fl;
        t_rdy[n_rows] = rdy;
        t_ev[n_rows] = ev;
        t_e1[n_rows] = e1;
        t_e2[n_rows] = e2;
        t_stag[n_rows] = stag;
        t_byp[n_rows] = byp;
        n_rows++;
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // Expected source value from shadow or a committing slot
    function automatic rename_pkg::xlen_t src_value(input logic [4:0] rs, input logic [1:0] b);
        if (b == 2'd0) begin
            return shadow[rs];
        end
        return commit_data[b - 1];
    endfunction

    task automatic check_row(input int r);
        int j;
        logic [4:0] rs1;
        logic [4:0] rs2;
        compare("rename_rdy", rename_rdy, t_rdy[r]);
        compare("ren_valid", ren_valid, t_ev[r]);
        for (int o = 0; o < 2; o++) begin
            // Lone slot 1 shows up in output slot 0
            j = (o == 0 && t_valid[r] == 2'b10) ? 1 : o;
            rs1 = t_src[r][j*10 +: 5];
            rs2 = t_src[r][j*10+5 +: 5];
            if (t_ev[r][o]) begin
                compare($sformatf("ren_dest_tag[%0d]", o), ren_dest_tag[o],
                        rename_pkg::rob_tag_t'(next_tag + o));
                compare($sformatf("ren_rd[%0d]", o), ren_rd[o], t_rd[r][j*5 +: 5]);
                compare($sformatf("ren_has_rd[%0d]", o), ren_has_rd[o], t_has_rd[r][j]);
                compare($sformatf("ren_rs1_renamed[%0d]", o), ren_rs1_renamed[o], t_e1[r][o]);
                compare($sformatf("ren_rs2_renamed[%0d]", o), ren_rs2_renamed[o], t_e2[r][o]);
                if (t_e1[r][o]) begin
                    compare($sformatf("ren_rs1_tag[%0d]", o), ren_rs1_tag[o], t_stag[r][o*8 +: 4]);
                end else begin
                    compare($sformatf("ren_rs1_data[%0d]", o), ren_rs1_data[o],
                            src_value(rs1, t_byp[r][o*4 +: 2]));
                end
                if (t_e2[r][o]) begin
                    compare($sformatf("ren_rs2_tag[%0d]", o), ren_rs2_tag[o],
                            t_stag[r][o*8+4 +: 4]);
                end else begin
                    compare($sformatf("ren_rs2_data[%0d]", o), ren_rs2_data[o],
                            src_value(rs2, t_byp[r][o*4+2 +: 2]));
                end
            end
        end
    endtask

    // Watchdog allows one clock per row plus a margin once reset ends
    initial begin
        wait (rst_n === 1'b1);
        #((n_rows + 20) * 8);
        $display("Watchdog expired before the table finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        flush = 1'b0;
        dispatch_rdy = 1'b0;
        dec_valid = '0;
        dec_has_rd = '0;
        dec_rd = '0;
        dec_rs1 = '0;
        dec_rs2 = '0;
        commit_we = '0;
        commit_rd = '0;
        commit_tag = '0;
        commit_data = '0;
        next_tag = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        // Basic rename then readers of x1 and x2
        add_row(2'b11, 2'b11, 1, 2, 3, 4, 5, 6, 1, 0, 0, 0, 0, 0, 0, 1, 2'b11, 0, 0, 0, 0);
        add_row(2'b01, 2'b01, 3, 0, 1, 2, 0, 0, 1, 0, 0, 0, 0, 0, 0, 1, 2'b01, 1, 1, 16'h0010, 0);
        // Intra-group forwarding and an x0 destination
        add_row(2'b11, 2'b11, 4, 5, 5, 0, 4, 6, 1, 0, 0, 0, 0, 0, 0, 1, 2'b11, 2'b10, 0, 16'h0300, 0);
        add_row(2'b11, 2'b11, 0, 7, 6, 7, 0, 0, 1, 0, 0, 0, 0, 0, 0, 1, 2'b11, 0, 0, 0, 0);
        // Commit bypass then committed values and a newer alias
        add_row(2'b01, 2'b01, 8, 0, 1, 2, 0, 0, 1, 2'b11, 1, 2, 0, 1, 0, 1, 2'b01, 0, 0, 0, 8'h09);
        add_row(2'b01, 2'b00, 0, 0, 1, 3, 0, 0, 1, 0, 0, 0, 0, 0, 0, 1, 2'b01, 0, 1, 16'h0020, 0);
        add_row(2'b01, 2'b01, 3, 0, 0, 0, 0, 0, 1, 2'b01, 3, 0, 2, 0, 0, 1, 2'b01, 0, 0, 0, 0);
        add_row(2'b01, 2'b00, 0, 0, 3, 5, 0, 0, 1, 0, 0, 0, 0, 0, 0, 1, 2'b01, 1, 1, 16'h0049, 0);
        // Compaction of a lone slot 1
        add_row(2'b10, 2'b10, 0, 9, 0, 0, 3, 6, 1, 0, 0, 0, 0, 0, 0, 1, 2'b01, 1, 0, 16'h0009, 0);
        // Dispatch stall
        add_row(2'b11, 2'b00, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 2'b00, 0, 0, 0, 0);
        // Fill the ROB and stall on one free entry until two are freed
        repeat (3) add_row(2'b11, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 1, 2'b11, 0, 0, 0, 0);
        add_row(2'b11, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 2'b00, 0, 0, 0, 0);
        add_row(2'b11, 0, 0, 0, 0, 0, 0, 0, 1, 2'b11, 4, 5, 3, 4, 0, 0, 2'b00, 0, 0, 0, 0);
        add_row(2'b11, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 1, 2'b11, 0, 0, 0, 0);
        // Flush then everything reads committed state from tag 0
        add_row(2'b00, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 1, 1, 2'b00, 0, 0, 0, 0);
        add_row(2'b11, 0, 0, 0, 1, 4, 8, 9, 1, 0, 0, 0, 0, 0, 0, 1, 2'b11, 0, 0, 0, 0);

        wait (rst_n);
        for (int r = 0; r < n_rows; r++) begin
            @(negedge clk);
            dec_valid = t_valid[r];
            dec_has_rd = t_has_rd[r];
            dec_rd = t_rd[r];
            dec_rs1 = {t_src[r][14:10], t_src[r][4:0]};
            dec_rs2 = {t_src[r][19:15], t_src[r][9:5]};
            dispatch_rdy = t_disp[r];
            flush = t_flush[r];
            commit_we = t_cwe[r];
            commit_rd = t_crd[r];
            commit_tag = t_ctag[r];
            commit_data[0] = $random(seed);
            commit_data[1] = $random(seed);
            // Sample 1 ns before the accepting edge
            #3;
            check_row(r);
            @(posedge clk);
            for (int c = 0; c < 2; c++) begin
                if (t_cwe[r][c] && commit_rd[c] != 0) begin
                    shadow[commit_rd[c]] = commit_data[c];
                end
            end
            if (t_flush[r]) begin
                next_tag = '0;
            end else if (t_rdy[r]) begin
                next_tag = next_tag + t_valid[r][0] + t_valid[r][1];
            end
        end

        $display("Summary: rows=%0d checks=%0d errors=%0d", n_rows, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: test/tb_clock.sv
/* Testbench clock and reset
   8 ns clock, reset held low for 16 cycles */
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Release on a falling edge, away from sampling
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: verilog.f
verilog/rename_pkg.sv
verilog/rat_prf.sv
verilog/rob_tag_alloc.sv
verilog/rename.sv
verilog/rename_top.sv
test/tb_clock.sv
test/rename_assert.sv
test/rename_tb.sv

// File: verilog/rat_prf.sv
/* Register/alias file
   Committed value plus speculative ROB tag for each architectural register */
`timescale 1ns/1ns

module rat_prf (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              flush,
    // Source reads, one pair per slot
    input  rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] rs1_addr,
    input  rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] rs2_addr,
    output logic                  [rename_pkg::pipe_width-1:0] rd1_renamed,
    output rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] rd1_tag,
    output rename_pkg::xlen_t     [rename_pkg::pipe_width-1:0] rd1_data,
    output logic                  [rename_pkg::pipe_width-1:0] rd2_renamed,
    output rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] rd2_tag,
    output rename_pkg::xlen_t     [rename_pkg::pipe_width-1:0] rd2_data,
    // Speculative alias writes from rename
    input  logic                  [rename_pkg::pipe_width-1:0] rat_we,
    input  rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] rat_rd,
    input  rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] rat_tag,
    // In-order commit writes from the ROB
    input  logic                  [rename_pkg::pipe_width-1:0] commit_we,
    input  rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] commit_rd,
    input  rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] commit_tag,
    input  rename_pkg::xlen_t     [rename_pkg::pipe_width-1:0] commit_data
);

    rename_pkg::xlen_t              reg_data [rename_pkg::arch_regs];
    rename_pkg::rob_tag_t           reg_tag  [rename_pkg::arch_regs];
    logic [rename_pkg::arch_regs-1:0] reg_renamed;

    // --------------------
    // Asynchronous reads
    // --------------------
    // x0 reads zero and is never renamed
    always_comb begin
        for (int i = 0; i < rename_pkg::pipe_width; i++) begin
            rd1_renamed[i] = (rs1_addr[i] != '0) && reg_renamed[rs1_addr[i]];
            rd1_tag[i]     = rd1_renamed[i] ? reg_tag[rs1_addr[i]] : '0;
            rd1_data[i]    = (rs1_addr[i] != '0) ? reg_data[rs1_addr[i]] : '0;
            rd2_renamed[i] = (rs2_addr[i] != '0) && reg_renamed[rs2_addr[i]];
            rd2_tag[i]     = rd2_renamed[i] ? reg_tag[rs2_addr[i]] : '0;
            rd2_data[i]    = (rs2_addr[i] != '0) ? reg_data[rs2_addr[i]] : '0;
        end
    end

    // --------------------
    // Data and alias flags
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_renamed <= '0;
            for (int r = 0; r < rename_pkg::arch_regs; r++) begin
                reg_data[r] <= '0;
            end
        end else begin
            // Commits first, a same-edge alias write then overrides the flag
            for (int c = 0; c < rename_pkg::pipe_width; c++) begin
                if (commit_we[c] && (commit_rd[c] != '0)) begin
                    reg_data[commit_rd[c]] <= commit_data[c];
                    // Only the youngest alias is released
                    if (reg_renamed[commit_rd[c]] && (reg_tag[commit_rd[c]] == commit_tag[c])) begin
                        reg_renamed[commit_rd[c]] <= 1'b0;
                    end
                end
            end
            for (int i = 0; i < rename_pkg::pipe_width; i++) begin
                if (rat_we[i] && (rat_rd[i] != '0)) begin
                    reg_renamed[rat_rd[i]] <= 1'b1;
                end
            end
            // Flush drops every speculative mapping, data stays
            if (flush) begin
                reg_renamed <= '0;
            end
        end
    end

    // Alias tags, slot 1 written last so the younger one wins
    always_ff @(posedge clk) begin
        for (int i = 0; i < rename_pkg::pipe_width; i++) begin
            if (rat_we[i] && (rat_rd[i] != '0)) begin
                reg_tag[rat_rd[i]] <= rat_tag[i];
            end
        end
    end

endmodule

// File: verilog/rename.sv
/* Two-wide rename stage
   Tags two instructions, forwards within the group, compacts and bypasses commits */
`timescale 1ns/1ns

module rename (
    // Decode side
    input  logic                  [rename_pkg::pipe_width-1:0] dec_valid,
    input  rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] dec_rd,
    input  logic                  [rename_pkg::pipe_width-1:0] dec_has_rd,
    input  rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] dec_rs1,
    input  rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] dec_rs2,
    output logic                                               rename_rdy,
    // Dispatch side
    input  logic                                               dispatch_rdy,
    output logic                  [rename_pkg::pipe_width-1:0] ren_valid,
    output rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] ren_dest_tag,
    output rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] ren_rd,
    output logic                  [rename_pkg::pipe_width-1:0] ren_has_rd,
    output logic                  [rename_pkg::pipe_width-1:0] ren_rs1_renamed,
    output rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] ren_rs1_tag,
    output rename_pkg::xlen_t     [rename_pkg::pipe_width-1:0] ren_rs1_data,
    output logic                  [rename_pkg::pipe_width-1:0] ren_rs2_renamed,
    output rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] ren_rs2_tag,
    output rename_pkg::xlen_t     [rename_pkg::pipe_width-1:0] ren_rs2_data,
    // Alias file reads and writes
    input  logic                  [rename_pkg::pipe_width-1:0] rd1_renamed,
    input  rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] rd1_tag,
    input  rename_pkg::xlen_t     [rename_pkg::pipe_width-1:0] rd1_data,
    input  logic                  [rename_pkg::pipe_width-1:0] rd2_renamed,
    input  rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] rd2_tag,
    input  rename_pkg::xlen_t     [rename_pkg::pipe_width-1:0] rd2_data,
    output logic                  [rename_pkg::pipe_width-1:0] rat_we,
    output rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] rat_rd,
    output rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] rat_tag,
    // Tag allocator
    output logic                  [rename_pkg::pipe_width-1:0] alloc_req,
    output logic                  [rename_pkg::pipe_width-1:0] alloc_take,
    input  logic                  [rename_pkg::pipe_width-1:0] alloc_gnt,
    input  rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] alloc_tag,
    // ROB commit, for the bypass
    input  logic                  [rename_pkg::pipe_width-1:0] commit_we,
    input  rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] commit_tag,
    input  rename_pkg::xlen_t     [rename_pkg::pipe_width-1:0] commit_data
);

    logic                                      gnts_ok;
    logic                                      fwd_ok;
    logic                                      compact;
    logic                 [rename_pkg::pipe_width-1:0] slot_valid;
    logic                 [rename_pkg::pipe_width-1:0] s1_ren;
    logic                 [rename_pkg::pipe_width-1:0] s2_ren;
    rename_pkg::rob_tag_t [rename_pkg::pipe_width-1:0] s1_tag;
    rename_pkg::rob_tag_t [rename_pkg::pipe_width-1:0] s2_tag;

    // --------------------
    // Allocation handshake
    // --------------------
    // Whole group or nothing
    assign gnts_ok    = &(~dec_valid | alloc_gnt);
    assign rename_rdy = dispatch_rdy && gnts_ok;
    assign alloc_req  = dec_valid;
    assign slot_valid = dec_valid & {rename_pkg::pipe_width{rename_rdy}};
    assign alloc_take = slot_valid;

    // Alias writes, x0 never aliased
    always_comb begin
        for (int i = 0; i < rename_pkg::pipe_width; i++) begin
            rat_we[i] = slot_valid[i] && dec_has_rd[i] && (dec_rd[i] != '0);
        end
    end
    assign rat_rd  = dec_rd;
    assign rat_tag = alloc_tag;

    // --------------------
    // Intra-group forwarding
    // --------------------
    assign fwd_ok = dec_valid[0] && dec_has_rd[0] && (dec_rd[0] != '0);

    always_comb begin
        s1_ren = rd1_renamed;
        s1_tag = rd1_tag;
        s2_ren = rd2_renamed;
        s2_tag = rd2_tag;
        // Slot 1 reads what slot 0 is about to write
        if (fwd_ok && (dec_rs1[1] == dec_rd[0])) begin
            s1_ren[1] = 1'b1;
            s1_tag[1] = alloc_tag[0];
        end
        if (fwd_ok && (dec_rs2[1] == dec_rd[0])) begin
            s2_ren[1] = 1'b1;
            s2_tag[1] = alloc_tag[0];
        end
    end

    // --------------------
    // Compaction and bypass
    // --------------------
    assign compact = !slot_valid[0] && slot_valid[1];

    always_comb begin
        int j;
        for (int o = 0; o < rename_pkg::pipe_width; o++) begin
            // Lone slot 1 moves down
            j = (o == 0 && compact) ? 1 : o;
            ren_valid[o]       = slot_valid[j] && !(o == 1 && compact);
            ren_dest_tag[o]    = alloc_tag[j];
            ren_rd[o]          = dec_rd[j];
            ren_has_rd[o]      = dec_has_rd[j];
            ren_rs1_renamed[o] = s1_ren[j];
            ren_rs1_tag[o]     = s1_tag[j];
            ren_rs1_data[o]    = s1_ren[j] ? '0 : rd1_data[j];
            ren_rs2_renamed[o] = s2_ren[j];
            ren_rs2_tag[o]     = s2_tag[j];
            ren_rs2_data[o]    = s2_ren[j] ? '0 : rd2_data[j];
            // Invalid slot shows all zero
            if (!ren_valid[o]) begin
                ren_dest_tag[o]    = '0;
                ren_rd[o]          = '0;
                ren_has_rd[o]      = 1'b0;
                ren_rs1_renamed[o] = 1'b0;
                ren_rs1_tag[o]     = '0;
                ren_rs1_data[o]    = '0;
                ren_rs2_renamed[o] = 1'b0;
                ren_rs2_tag[o]     = '0;
                ren_rs2_data[o]    = '0;
            end
            // Producer retiring right now, take its value
            for (int c = 0; c < rename_pkg::pipe_width; c++) begin
                if (commit_we[c] && ren_rs1_renamed[o] && (ren_rs1_tag[o] == commit_tag[c])) begin
                    ren_rs1_renamed[o] = 1'b0;
                    ren_rs1_tag[o]     = '0;
                    ren_rs1_data[o]    = commit_data[c];
                end
                if (commit_we[c] && ren_rs2_renamed[o] && (ren_rs2_tag[o] == commit_tag[c])) begin
                    ren_rs2_renamed[o] = 1'b0;
                    ren_rs2_tag[o]     = '0;
                    ren_rs2_data[o]    = commit_data[c];
                end
            end
        end
    end

endmodule

// File: verilog/rename_pkg.sv
/* Rename slice shared definitions
   Sizes and vector types used by the rename stage, alias file and tag allocator */
package rename_pkg;

    // --------------------
    // Sizes
    // --------------------

    // Instructions renamed per cycle
    localparam int pipe_width = 2;

    // Integer architectural registers
    localparam int arch_regs = 32;

    // ROB entries, so also the tag space
    localparam int rob_depth = 16;

    // --------------------
    // Vector types
    // --------------------

    // Architectural register index
    typedef logic [$clog2(arch_regs)-1:0] arch_reg_t;

    // ROB tag, one per entry
    typedef logic [$clog2(rob_depth)-1:0] rob_tag_t;

    // Register data word
    typedef logic [31:0] xlen_t;

    // ROB occupancy, 0 up to rob_depth inclusive
    typedef logic [$clog2(rob_depth):0] rob_count_t;

endpackage

// File: verilog/rename_top.sv
/* Rename slice top level
   Rename stage with its alias file and ROB tag allocator */
`timescale 1ns/1ns

module rename_top (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               flush,
    // Decode
    input  logic                  [rename_pkg::pipe_width-1:0] dec_valid,
    input  rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] dec_rd,
    input  logic                  [rename_pkg::pipe_width-1:0] dec_has_rd,
    input  rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] dec_rs1,
    input  rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] dec_rs2,
    output logic                                               rename_rdy,
    // Dispatch
    input  logic                                               dispatch_rdy,
    output logic                  [rename_pkg::pipe_width-1:0] ren_valid,
    output rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] ren_dest_tag,
    output rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] ren_rd,
    output logic                  [rename_pkg::pipe_width-1:0] ren_has_rd,
    output logic                  [rename_pkg::pipe_width-1:0] ren_rs1_renamed,
    output rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] ren_rs1_tag,
    output rename_pkg::xlen_t     [rename_pkg::pipe_width-1:0] ren_rs1_data,
    output logic                  [rename_pkg::pipe_width-1:0] ren_rs2_renamed,
    output rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] ren_rs2_tag,
    output rename_pkg::xlen_t     [rename_pkg::pipe_width-1:0] ren_rs2_data,
    // ROB commit
    input  logic                  [rename_pkg::pipe_width-1:0] commit_we,
    input  rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] commit_rd,
    input  rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] commit_tag,
    input  rename_pkg::xlen_t     [rename_pkg::pipe_width-1:0] commit_data
);

    // Alias file read results
    logic                  [rename_pkg::pipe_width-1:0] rd1_renamed;
    rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] rd1_tag;
    rename_pkg::xlen_t     [rename_pkg::pipe_width-1:0] rd1_data;
    logic                  [rename_pkg::pipe_width-1:0] rd2_renamed;
    rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] rd2_tag;
    rename_pkg::xlen_t     [rename_pkg::pipe_width-1:0] rd2_data;
    // Alias writes
    logic                  [rename_pkg::pipe_width-1:0] rat_we;
    rename_pkg::arch_reg_t [rename_pkg::pipe_width-1:0] rat_rd;
    rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] rat_tag;
    // Allocator
    logic                  [rename_pkg::pipe_width-1:0] alloc_req;
    logic                  [rename_pkg::pipe_width-1:0] alloc_take;
    logic                  [rename_pkg::pipe_width-1:0] alloc_gnt;
    rename_pkg::rob_tag_t  [rename_pkg::pipe_width-1:0] alloc_tag;

    rename rename_i (
        .dec_valid(dec_valid), .dec_rd(dec_rd), .dec_has_rd(dec_has_rd),
        .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .rename_rdy(rename_rdy),
        .dispatch_rdy(dispatch_rdy), .ren_valid(ren_valid),
        .ren_dest_tag(ren_dest_tag), .ren_rd(ren_rd), .ren_has_rd(ren_has_rd),
        .ren_rs1_renamed(ren_rs1_renamed), .ren_rs1_tag(ren_rs1_tag),
        .ren_rs1_data(ren_rs1_data), .ren_rs2_renamed(ren_rs2_renamed),
        .ren_rs2_tag(ren_rs2_tag), .ren_rs2_data(ren_rs2_data),
        .rd1_renamed(rd1_renamed), .rd1_tag(rd1_tag), .rd1_data(rd1_data),
        .rd2_renamed(rd2_renamed), .rd2_tag(rd2_tag), .rd2_data(rd2_data),
        .rat_we(rat_we), .rat_rd(rat_rd), .rat_tag(rat_tag),
        .alloc_req(alloc_req), .alloc_take(alloc_take),
        .alloc_gnt(alloc_gnt), .alloc_tag(alloc_tag),
        .commit_we(commit_we), .commit_tag(commit_tag), .commit_data(commit_data)
    );

    // Sources address the alias file straight from decode
    rat_prf rat_prf_i (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .rs1_addr(dec_rs1), .rs2_addr(dec_rs2),
        .rd1_renamed(rd1_renamed), .rd1_tag(rd1_tag), .rd1_data(rd1_data),
        .rd2_renamed(rd2_renamed), .rd2_tag(rd2_tag), .rd2_data(rd2_data),
        .rat_we(rat_we), .rat_rd(rat_rd), .rat_tag(rat_tag),
        .commit_we(commit_we), .commit_rd(commit_rd),
        .commit_tag(commit_tag), .commit_data(commit_data)
    );

    rob_tag_alloc rob_tag_alloc_i (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .alloc_req(alloc_req), .alloc_take(alloc_take), .commit_we(commit_we),
        .alloc_gnt(alloc_gnt), .alloc_tag(alloc_tag)
    );

endmodule

// File: verilog/rob_tag_alloc.sv
/* ROB tag allocator
   Circular tag issue at the tail, freed in order by commits */
`timescale 1ns/1ns

module rob_tag_alloc (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             flush,
    input  logic                 [rename_pkg::pipe_width-1:0] alloc_req,
    input  logic                 [rename_pkg::pipe_width-1:0] alloc_take,
    input  logic                 [rename_pkg::pipe_width-1:0] commit_we,
    output logic                 [rename_pkg::pipe_width-1:0] alloc_gnt,
    output rename_pkg::rob_tag_t [rename_pkg::pipe_width-1:0] alloc_tag
);

    rename_pkg::rob_tag_t   tail;
    rename_pkg::rob_count_t count;
    rename_pkg::rob_count_t free_cnt;
    rename_pkg::rob_count_t n_take;
    rename_pkg::rob_count_t n_commit;

    assign free_cnt = rename_pkg::rob_count_t'(rename_pkg::rob_depth) - count;

    // --------------------
    // Offer and grant
    // --------------------
    // Lone slot 1 request takes the tail itself
    assign alloc_tag[0] = tail;
    assign alloc_tag[1] = alloc_req[0] ? rename_pkg::rob_tag_t'(tail + 1'b1) : tail;

    assign alloc_gnt[0] = alloc_req[0] && (free_cnt != '0);
    assign alloc_gnt[1] = alloc_req[1] &&
                          ((free_cnt >= 2) || ((free_cnt != '0) && !alloc_req[0]));

    // Takes and frees this cycle
    always_comb begin
        n_take   = '0;
        n_commit = '0;
        for (int i = 0; i < rename_pkg::pipe_width; i++) begin
            n_take   = n_take + rename_pkg::rob_count_t'(alloc_take[i]);
            n_commit = n_commit + rename_pkg::rob_count_t'(commit_we[i]);
        end
    end

    // --------------------
    // Pointer and count
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            tail  <= '0;
            count <= '0;
        end else begin
            // Tail wraps at rob_depth
            tail  <= tail + rename_pkg::rob_tag_t'(n_take);
            count <= count + n_take - n_commit;
        end
    end

endmodule
